/* hdl/zx_mem_config.svh */
`ifndef ZX_MEM_CONFIG_SVH
`define ZX_MEM_CONFIG_SVH

// Bus widths
`define ZX_CPU_AW   17  // Bit 16 flags I/O, bits 15:0 are the Z80 address
`define ZX_SRAM_AW  19  // 512K external SRAM
`define ZX_ROM_AW   15  // Two 16K ROM pages
`define ZX_VID_AW   14  // Offset inside one 16K bank
`define ZX_DATA_W   8
`define ZX_BANK_W   3   // Eight 16K banks

// Fixed bank numbers
`define ZX_RAM_BASE     2'd1  // SRAM bits 18:17 above the 128K of banks
`define ZX_BANK_SCREEN  3'd5  // Normal screen, also the 4000 window
`define ZX_BANK_SHADOW  3'd7  // Shadow screen
`define ZX_BANK_FIXED   3'd2  // Always at 8000

// Bytes per screen pass
// 6144 bitmap plus 768 attributes
`define ZX_VID_BYTES 6912

// Port 7FFD decode looks at A15 and A1 only
`define ZX_PAGE_PORT_MASK   16'h8002
`define ZX_PAGE_PORT_MATCH  16'h0000

`endif

/* hdl/zx_mem_pkg.sv */
`include "zx_mem_config.svh"

package zx_mem_pkg;

  // Plain vectors
  typedef logic [`ZX_CPU_AW-1:0]  cpu_addr_t;
  typedef logic [`ZX_DATA_W-1:0]  data_t;
  typedef logic [`ZX_SRAM_AW-1:0] sram_addr_t;
  typedef logic [`ZX_ROM_AW-1:0]  rom_addr_t;
  typedef logic [`ZX_VID_AW-1:0]  vid_addr_t;
  typedef logic [`ZX_BANK_W-1:0]  bank_t;

  // Wishbone classic request, held by the master until ack
  typedef struct packed {
    logic      cyc;
    logic      stb;
    logic      we;
    cpu_addr_t adr;
    data_t     dat;  // CPU write data
  } wb_req_t;

  // Same bit layout as the 128K port 7FFD
  typedef struct packed {
    logic [1:0] spare;
    logic       lock;           // Sticky until reset
    logic       rom_sel;        // 0 = 128 editor, 1 = 48 BASIC
    logic       shadow_screen;  // Screen from bank 7
    bank_t      ram_bank;       // Bank seen at C000
  } page_reg_t;

  typedef enum logic [1:0] {KIND_NONE, KIND_ROM, KIND_RAM, KIND_IO_PAGE} access_kind_t;

  // Mapper result for the sequencer
  typedef struct packed {
    access_kind_t kind;
    sram_addr_t   sram_addr;
    rom_addr_t    rom_addr;
    logic         io_write;   // Page port write
  } access_t;

  typedef enum logic [2:0] {IDLE, ROM_RD, WAIT_SLOT, SRAM_CYC, ACK, RECOVER} seq_state_t;

endpackage

/* hdl/zx_page_mapper.sv */
`timescale 1ns/1ps
`include "zx_mem_config.svh"

module zx_page_mapper (
  input  logic                   clk,
  input  logic                   arst_n,
  input  zx_mem_pkg::wb_req_t    req,         // CPU request
  input  logic                   accept,      // Access committed this cycle
  output zx_mem_pkg::page_reg_t  page,
  output zx_mem_pkg::access_t    access,
  input  zx_mem_pkg::vid_addr_t  vid_offset,  // Screen fetch offset
  output zx_mem_pkg::sram_addr_t vid_addr
);
  import zx_mem_pkg::*;

  page_reg_t   page_q;
  logic [15:0] z80_adr;
  logic        is_io;
  logic        port_hit;
  bank_t       cpu_bank;
  bank_t       vid_bank;
  logic        page_wr;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////
  assign z80_adr  = req.adr[15:0];
  assign is_io    = req.adr[`ZX_CPU_AW-1];  // I/O flag above the Z80 address
  assign port_hit = (z80_adr & `ZX_PAGE_PORT_MASK) == `ZX_PAGE_PORT_MATCH;

  // Bank per 16K window
  always_comb begin
    case (z80_adr[15:14])
      2'b01:   cpu_bank = `ZX_BANK_SCREEN;
      2'b10:   cpu_bank = `ZX_BANK_FIXED;
      2'b11:   cpu_bank = page_q.ram_bank;  // Paged window
      default: cpu_bank = '0;               // ROM window, not used
    endcase
  end

  always_comb begin
    access.kind = KIND_NONE;  // Unmatched I/O
    if (is_io) begin
      if (port_hit) begin
        access.kind = KIND_IO_PAGE;
      end
    end else if (z80_adr[15:14] == 2'b00) begin
      access.kind = KIND_ROM;
    end else begin
      access.kind = KIND_RAM;
    end
    access.sram_addr = {`ZX_RAM_BASE, cpu_bank, z80_adr[13:0]};
    access.rom_addr  = {page_q.rom_sel, z80_adr[13:0]};
    access.io_write  = req.cyc & req.stb & req.we & is_io & port_hit;
  end

  //////////////////////////////////////////////////
  // Paging register
  //////////////////////////////////////////////////
  // Once locked only reset unlocks
  assign page_wr = accept & access.io_write & ~page_q.lock;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      page_q <= '0;  // Bank 0, normal screen, ROM 0
    end else if (page_wr) begin
      page_q <= page_reg_t'(req.dat);
    end
  end

  assign page = page_q;

  // Screen source
  assign vid_bank = page_q.shadow_screen ? `ZX_BANK_SHADOW : `ZX_BANK_SCREEN;
  assign vid_addr = {`ZX_RAM_BASE, vid_bank, vid_offset};

endmodule

/* hdl/zx_slot_timer.sv */
`timescale 1ns/1ps
`include "zx_mem_config.svh"

module zx_slot_timer (
  input  logic                  clk,
  input  logic                  arst_n,
  output logic [1:0]            slot,        // 0-1 screen, 2-3 CPU
  input  logic                  fetch_done,  // Screen byte captured
  output zx_mem_pkg::vid_addr_t vid_offset
);
  import zx_mem_pkg::*;

  localparam vid_addr_t LAST_OFFSET = vid_addr_t'(`ZX_VID_BYTES - 1);

  logic [1:0] slot_q;
  vid_addr_t  offset_q;
  logic       wrap;

  //////////////////////////////////////////////////
  // Slot counter
  //////////////////////////////////////////////////
  // Free running, never stalls
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      slot_q <= 2'd0;
    end else begin
      slot_q <= slot_q + 2'd1;
    end
  end

  //////////////////////////////////////////////////
  // Screen fetch offset
  //////////////////////////////////////////////////
  assign wrap = (offset_q == LAST_OFFSET);  // End of attributes

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      offset_q <= '0;
    end else if (fetch_done) begin
      if (wrap) begin
        offset_q <= '0;  // Back to bitmap start
      end else begin
        offset_q <= offset_q + vid_addr_t'(1);
      end
    end
  end

  assign slot       = slot_q;
  assign vid_offset = offset_q;

endmodule

/* hdl/zx_sram_sequencer.sv */
`timescale 1ns/1ps

module zx_sram_sequencer (
  input  logic                   clk,
  input  logic                   arst_n,
  input  zx_mem_pkg::wb_req_t    req,
  input  zx_mem_pkg::access_t    access,
  input  zx_mem_pkg::page_reg_t  page,
  input  logic [1:0]             slot,
  input  zx_mem_pkg::sram_addr_t vid_addr,
  output logic                   accept,
  output logic                   fetch_done,
  output logic                   ack,
  output zx_mem_pkg::data_t      dat_o,
  output zx_mem_pkg::rom_addr_t  rom_addr,
  input  zx_mem_pkg::data_t      rom_data,
  output zx_mem_pkg::sram_addr_t sram_addr,
  output zx_mem_pkg::data_t      sram_wdata,
  output logic                   sram_oe,     // Write data driven onto the SRAM
  output logic                   sram_we_n,
  input  zx_mem_pkg::data_t      sram_rdata,
  output zx_mem_pkg::data_t      vid_data,
  output logic                   vid_valid
);
  import zx_mem_pkg::*;

  seq_state_t   state;
  seq_state_t   state_nx;
  access_kind_t kind_q;
  sram_addr_t   cpu_addr_q;
  rom_addr_t    rom_addr_q;
  data_t        wdata_q;
  logic         we_q;
  data_t        rd_mux;
  logic         cpu_slot;
  logic         sram_cyc;

  //////////////////////////////////////////////////
  // CPU side FSM
  //////////////////////////////////////////////////
  assign accept = (state == IDLE) & req.cyc & req.stb;

  always_comb begin
    state_nx = state;
    case (state)
      IDLE: begin
        if (accept) begin
          if (access.kind == KIND_RAM) begin
            // Go straight in when slot 2 comes next
            state_nx = (slot == 2'd1) ? SRAM_CYC : WAIT_SLOT;
          end else begin
            state_nx = ROM_RD;  // ROM and all I/O
          end
        end
      end
      ROM_RD:    state_nx = ACK;
      WAIT_SLOT: if (slot == 2'd1) state_nx = SRAM_CYC;
      SRAM_CYC:  if (slot == 2'd3) state_nx = ACK;  // Slots 2 and 3
      ACK:       state_nx = RECOVER;
      RECOVER:   state_nx = IDLE;  // Master drops stb here
      default:   state_nx = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nx;
    end
  end

  // Request held for the whole access
  always_ff @(posedge clk) begin
    if (accept) begin
      kind_q     <= access.kind;
      cpu_addr_q <= access.sram_addr;
      rom_addr_q <= access.rom_addr;
      wdata_q    <= req.dat;
      we_q       <= req.we;
    end
  end

  // Read data for the short path
  always_comb begin
    case (kind_q)
      KIND_ROM:     rd_mux = rom_data;
      KIND_IO_PAGE: rd_mux = data_t'(page);
      default:      rd_mux = '0;  // Unmatched port reads 0
    endcase
  end

  always_ff @(posedge clk) begin
    if (state == ROM_RD) begin
      dat_o <= rd_mux;
    end else if (sram_cyc && slot == 2'd3) begin
      dat_o <= sram_rdata;  // End of CPU slot
    end
  end

  assign ack      = (state == ACK);
  assign rom_addr = rom_addr_q;

  //////////////////////////////////////////////////
  // SRAM pins
  //////////////////////////////////////////////////
  assign cpu_slot   = slot[1];
  assign sram_cyc   = (state == SRAM_CYC);
  assign sram_addr  = cpu_slot ? cpu_addr_q : vid_addr;  // One mux for both ports
  assign sram_wdata = wdata_q;
  assign sram_oe    = sram_cyc & we_q;
  assign sram_we_n  = ~(sram_cyc & we_q & (slot == 2'd2));  // Write strobe in slot 2 only

  // Screen byte at end of slot 1
  assign fetch_done = (slot == 2'd1);

  always_ff @(posedge clk) begin
    if (fetch_done) vid_data <= sram_rdata;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vid_valid <= 1'b0;
    end else begin
      vid_valid <= fetch_done;  // One cycle after capture
    end
  end

endmodule

/* hdl/zx_memsys.sv */
`timescale 1ns/1ps

module zx_memsys (
  input  logic                   clk,
  input  logic                   arst_n,
  // Wishbone slave, CPU side
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  zx_mem_pkg::cpu_addr_t  wb_adr,    // Bit 16 set for I/O
  input  zx_mem_pkg::data_t      wb_dat_i,
  output zx_mem_pkg::data_t      wb_dat_o,
  output logic                   wb_ack,
  // ROM
  output zx_mem_pkg::rom_addr_t  rom_addr,
  input  zx_mem_pkg::data_t      rom_data,
  // External SRAM
  output zx_mem_pkg::sram_addr_t sram_addr,
  output zx_mem_pkg::data_t      sram_wdata,
  input  zx_mem_pkg::data_t      sram_rdata,
  output logic                   sram_oe,
  output logic                   sram_we_n,
  // Screen bytes to the video side
  output zx_mem_pkg::data_t      vid_data,
  output logic                   vid_valid
);
  import zx_mem_pkg::*;

  wb_req_t    req;
  page_reg_t  page;
  access_t    access;
  vid_addr_t  vid_offset;
  sram_addr_t vid_addr;
  logic [1:0] slot;
  logic       accept;
  logic       fetch_done;

  assign req = '{cyc: wb_cyc, stb: wb_stb, we: wb_we, adr: wb_adr, dat: wb_dat_i};

  //////////////////////////////////////////////////
  // Instances
  //////////////////////////////////////////////////
  zx_page_mapper i_mapper (
    .clk        (clk),
    .arst_n     (arst_n),
    .req        (req),
    .accept     (accept),
    .page       (page),
    .access     (access),
    .vid_offset (vid_offset),
    .vid_addr   (vid_addr)
  );

  zx_slot_timer i_timer (
    .clk        (clk),
    .arst_n     (arst_n),
    .slot       (slot),
    .fetch_done (fetch_done),
    .vid_offset (vid_offset)
  );

  zx_sram_sequencer i_seq (
    .clk        (clk),
    .arst_n     (arst_n),
    .req        (req),
    .access     (access),
    .page       (page),
    .slot       (slot),
    .vid_addr   (vid_addr),
    .accept     (accept),
    .fetch_done (fetch_done),
    .ack        (wb_ack),
    .dat_o      (wb_dat_o),
    .rom_addr   (rom_addr),
    .rom_data   (rom_data),
    .sram_addr  (sram_addr),
    .sram_wdata (sram_wdata),
    .sram_oe    (sram_oe),
    .sram_we_n  (sram_we_n),
    .sram_rdata (sram_rdata),
    .vid_data   (vid_data),
    .vid_valid  (vid_valid)
  );

endmodule

/* bench/zx_memsys_properties.sv */
`timescale 1ns/1ps

module zx_memsys_properties (
  input logic clk,
  input logic arst_n,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic sram_we_n,
  input logic vid_valid
);

  logic [1:0] phase;  // Slot number counted from reset

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      phase <= 2'd0;
    end else begin
      phase <= phase + 2'd1;
    end
  end

  //////////////////////////////////////////////////
  // Wishbone
  //////////////////////////////////////////////////
  ack_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
    wb_ack |=> !wb_ack)
    else $error("ack held longer than one cycle");

  ack_needs_request: assert property (@(posedge clk) disable iff (!arst_n)
    wb_ack |-> (wb_cyc && wb_stb))
    else $error("ack without cyc and stb");

  //////////////////////////////////////////////////
  // SRAM and screen timing
  //////////////////////////////////////////////////
  we_in_slot2: assert property (@(posedge clk) disable iff (!arst_n)
    !sram_we_n |-> (phase == 2'd2))
    else $error("SRAM write strobe outside slot 2");

  // Screen byte every 4 cycles
  vid_period: assert property (@(posedge clk) disable iff (!arst_n)
    vid_valid |=> !vid_valid [*3] ##1 vid_valid)
    else $error("vid_valid not spaced by 4 cycles");

endmodule

bind zx_memsys zx_memsys_properties i_props (
  .clk       (clk),
  .arst_n    (arst_n),
  .wb_cyc    (wb_cyc),
  .wb_stb    (wb_stb),
  .wb_ack    (wb_ack),
  .sram_we_n (sram_we_n),
  .vid_valid (vid_valid)
);

/* bench/zx_memsys_tb.sv */
`timescale 1ns/1ps
`include "zx_mem_config.svh"

module zx_memsys_tb;

  // Longest test follows one full screen pass, 4 cycles per byte
  localparam int TIMEOUT_CYCLES = `ZX_VID_BYTES * 4 + 8000;
  localparam int WINDOW_CYCLES  = 400;  // Multiple of 4

  logic        clk = 1'b0;
  logic        arst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [16:0] wb_adr;
  logic [7:0]  wb_dat_i;
  logic [7:0]  wb_dat_o;
  logic        wb_ack;
  logic [14:0] rom_addr;
  logic [7:0]  rom_data;
  logic [18:0] sram_addr;
  logic [7:0]  sram_wdata;
  logic [7:0]  sram_rdata;
  logic        sram_oe;
  logic        sram_we_n;
  logic [7:0]  vid_data;
  logic        vid_valid;

  logic [7:0]  sram_mem [0:(1 << `ZX_SRAM_AW) - 1];
  logic        mem_ready = 1'b0;
  logic [31:0] lfsr_q = 32'h44af868a;
  int          cycle_cnt = 0;
  int          vid_count;
  int          oe_cycles = 0;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;

  zx_memsys i_dut (.*);

  always #2 clk = ~clk;  // 4 ns period

  //////////////////////////////////////////////////
  // Memory models
  //////////////////////////////////////////////////
  function automatic logic [7:0] fill_byte(input logic [18:0] a);
    return a[7:0] ^ a[15:8] ^ {5'b0, a[18:16]} ^ 8'h5a;
  endfunction

  assign rom_data   = rom_addr[7:0] ^ 8'hA5;  // ROM pattern
  assign sram_rdata = sram_mem[sram_addr];

  always @(posedge clk) begin
    if (!mem_ready) begin  // First edge fills the whole array
      for (int i = 0; i < (1 << `ZX_SRAM_AW); i++) begin
        sram_mem[i] <= fill_byte(19'(i));
      end
      mem_ready <= 1'b1;
    end else if (!sram_we_n) begin
      sram_mem[sram_addr] <= sram_wdata;
    end
  end

  // Screen pulses since reset
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) vid_count <= 0;
    else if (vid_valid) vid_count <= vid_count + 1;
  end

  // Cycles with the SRAM data bus driven
  always @(posedge clk) begin
    if (sram_oe) oe_cycles <= oe_cycles + 1;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endtask

  // One Wishbone cycle, latency counted from stb
  task automatic bus_access(input logic we, input logic [16:0] adr, input logic [7:0] wdat,
                            output logic [7:0] rdat, output int lat);
    lat      = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_i = wdat;
    do begin
      @(posedge clk);
      #1;
      lat++;
    end while (!wb_ack);
    rdat = wb_dat_o;
    @(posedge clk);  // Drop stb in the cycle after ack
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(posedge clk);  // Stb seen low in the recovery cycle
    #1;
  endtask

  task automatic wait_vid();
    do begin
      @(posedge clk);
      #1;
    end while (!vid_valid);
  endtask

  function automatic logic [18:0] ram_addr(input logic [2:0] bank, input logic [13:0] off);
    return {2'b01, bank, off};
  endfunction

  task automatic report_test(input string name, input int errs_before);
    tests++;
    $display("%s: %0d errors", name, errors - errs_before);
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////
  task automatic follow_screen_fetch();
    int          e0;
    int          lat;
    logic [7:0]  rd;
    logic [13:0] off;
    e0 = errors;
    for (int i = 0; i < `ZX_VID_BYTES + 8; i++) begin  // Crosses the wrap
      wait_vid();
      off = 14'(vid_count % `ZX_VID_BYTES);
      check_value("vid_data", vid_data, fill_byte(ram_addr(3'd5, off)));
    end
    bus_access(1'b1, 17'h1_7FFD, 8'h08, rd, lat);  // Shadow screen on
    wait_vid();
    wait_vid();
    for (int i = 0; i < 16; i++) begin
      wait_vid();
      off = 14'(vid_count % `ZX_VID_BYTES);
      check_value("vid_data_shadow", vid_data, fill_byte(ram_addr(3'd7, off)));
    end
    bus_access(1'b1, 17'h1_7FFD, 8'h00, rd, lat);
    report_test("screen fetch", e0);
  endtask

  task automatic read_rom_window();
    int          e0;
    int          lat;
    logic [7:0]  rd;
    logic [15:0] a;
    e0 = errors;
    for (int i = 0; i < 24; i++) begin
      a = {2'b00, 14'(take_bits(14))};
      bus_access(1'b0, {1'b0, a}, 8'h00, rd, lat);
      check_value("rom_addr", rom_addr, {1'b0, a[13:0]});
      check_value("wb_dat_o", rd, a[7:0] ^ 8'hA5);
      check_value("rom_latency", lat, 2);
    end
    report_test("rom reads", e0);
  endtask

  task automatic write_read_ram();
    int          e0;
    int          o0;
    int          lat;
    logic [7:0]  rd;
    logic [7:0]  d;
    logic [1:0]  win;
    logic [13:0] off;
    logic [2:0]  bank;
    e0 = errors;
    for (int i = 0; i < 30; i++) begin
      win  = 2'(i % 3 + 1);
      off  = 14'(take_bits(14));
      d    = 8'(take_bits(8));
      bank = (win == 2'd1) ? 3'd5 : (win == 2'd2) ? 3'd2 : 3'd0;  // Page reg at 0
      o0   = oe_cycles;
      bus_access(1'b1, {1'b0, win, off}, d, rd, lat);
      check_value("sram_oe_cycles", oe_cycles - o0, 2);  // Slots 2 and 3
      check_value("sram_mem", sram_mem[ram_addr(bank, off)], d);
      o0 = oe_cycles;
      bus_access(1'b0, {1'b0, win, off}, 8'h00, rd, lat);
      check_value("sram_oe_cycles", oe_cycles - o0, 0);  // Reads keep it low
      check_value("wb_dat_o", rd, d);
    end
    report_test("ram windows", e0);
  endtask

  task automatic stress_back_to_back();
    int          e0;
    int          lat;
    int          t0;
    int          v0;
    logic [7:0]  rd;
    logic [7:0]  d;
    logic [15:0] a;
    e0 = errors;
    t0 = cycle_cnt;
    v0 = vid_count;
    for (int i = 0; i < 20; i++) begin
      a = {2'b10, 14'(take_bits(14))};  // Fixed bank 2
      d = 8'(take_bits(8));
      bus_access(1'b1, {1'b0, a}, d, rd, lat);
      if (lat < 3 || lat > 6) begin
        errors++;
        $display("RAM write took %0d cycles, outside 3 to 6", lat);
      end
      bus_access(1'b0, {1'b0, a}, 8'h00, rd, lat);
      if (lat < 3 || lat > 6) begin
        errors++;
        $display("RAM read took %0d cycles, outside 3 to 6", lat);
      end
      check_value("wb_dat_o", rd, d);
    end
    while (cycle_cnt < t0 + WINDOW_CYCLES) begin
      @(posedge clk);
      #1;
    end
    check_value("vid_pulses", vid_count - v0, WINDOW_CYCLES / 4);
    report_test("back to back", e0);
  endtask

  task automatic exercise_page_port();
    int         e0;
    int         lat;
    logic [7:0] rd;
    e0 = errors;
    bus_access(1'b1, 17'h1_7FFD, 8'h13, rd, lat);  // Bank 3, ROM 1
    bus_access(1'b0, 17'h1_7FFD, 8'h00, rd, lat);
    check_value("page_read", rd, 8'h13);
    check_value("io_latency", lat, 2);
    bus_access(1'b0, 17'h1_00FE, 8'h00, rd, lat);  // A1 set, no match
    check_value("other_io", rd, 8'h00);
    bus_access(1'b1, 17'h0_C123, 8'h6B, rd, lat);
    check_value("sram_mem_bank3", sram_mem[ram_addr(3'd3, 14'h0123)], 8'h6B);
    bus_access(1'b0, 17'h0_0123, 8'h00, rd, lat);
    check_value("rom_addr_page1", rom_addr, 15'h4123);
    check_value("wb_dat_o", rd, 8'h23 ^ 8'hA5);
    bus_access(1'b1, 17'h1_7FFD, 8'h33, rd, lat);  // Lock
    bus_access(1'b1, 17'h1_7FFD, 8'h05, rd, lat);
    bus_access(1'b0, 17'h1_7FFD, 8'h00, rd, lat);
    check_value("page_locked", rd, 8'h33);
    arst_n = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;
    bus_access(1'b0, 17'h1_7FFD, 8'h00, rd, lat);
    check_value("page_after_reset", rd, 8'h00);
    report_test("page port", e0);
  endtask

  //////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////
  initial begin
    arst_n   = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_i = '0;
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;
    follow_screen_fetch();  // Before any CPU write lands in bank 5
    read_rom_window();
    write_read_ram();
    stress_back_to_back();
    exercise_page_port();  // Lock needs the reset at its end
    $display("Done: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+hdl
hdl/zx_mem_pkg.sv
hdl/zx_page_mapper.sv
hdl/zx_slot_timer.sv
hdl/zx_sram_sequencer.sv
hdl/zx_memsys.sv
bench/zx_memsys_properties.sv
bench/zx_memsys_tb.sv

/* Makefile */
# Verilator build and run for the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= zx_memsys_tb
RTL_TOP   ?= zx_memsys
FLIST     ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# Status comes from grep, so a missing pass line fails the target
run: build
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^TEST PASS$$"

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
